//--- fm_eg.f
src/eg_cfg_pkg.sv
src/eg_core_pkg.sv
src/eg_delay_line.sv
src/eg_slot_ctrl.sv
src/eg_envelope.sv
src/eg_top.sv
dv/eg_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing
LFLAGS    = --lint-only --timing
TOP       = eg_tb
FLIST     = fm_eg.f
OBJ_DIR   = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LFLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)

//--- dv/eg_tb.sv
//==========================================================
// envelope generator testbench: table of slot settings and
// key events, four-phase host writes, per-slot level checks
//==========================================================
module eg_tb;

	localparam int NUM_ROWS = 6;

	typedef enum logic {KEY_ON, KEY_OFF} key_act_t;

	// row columns are ar, d1r, d1l, d2r, rr, tl, key, wait frames and expected level
	typedef struct packed {
		eg_cfg_pkg::rate5_t  ar;
		eg_cfg_pkg::rate5_t  d1r;
		eg_cfg_pkg::d1l_t    d1l;
		eg_cfg_pkg::rate5_t  d2r;
		eg_cfg_pkg::rate4_t  rr;
		eg_cfg_pkg::tl_t     tl;
		key_act_t            key;
		logic [9:0]          frames;
		eg_core_pkg::level_t exp;
	} row_t;

	logic                clk;
	logic                rst;
	eg_cfg_pkg::eg_wr_t  wr;
	logic                wr_req;
	logic                wr_ack;
	eg_core_pkg::level_t eg;
	eg_cfg_pkg::slot_t   out_slot;

	row_t                rows [NUM_ROWS];
	string               names [NUM_ROWS];
	eg_core_pkg::level_t last_eg [eg_cfg_pkg::NUM_SLOTS];
	int                  cycles;
	int                  limit;

	eg_top UUT (
		.clk      (clk),
		.rst      (rst),
		.wr       (wr),
		.wr_req   (wr_req),
		.wr_ack   (wr_ack),
		.eg       (eg),
		.out_slot (out_slot)
	);

	always #10 clk = ~clk;

	// latest output per slot sampled away from the rising edge
	always @(negedge clk) begin
		if (!rst)
			last_eg[out_slot] = eg;
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (limit != 0 && cycles >= limit) begin
			$display("timeout: run still going after %0d clocks", cycles);
			$display("Something failed");
			$fatal(1);
		end
	end

	task automatic check_level(input string name, input eg_core_pkg::level_t exp,
		input eg_core_pkg::level_t act);
		if (act !== exp) begin
			$display("mismatch %s: expected %h, actual %h", name, exp, act);
			$display("Something failed");
			$fatal(1);
		end
	endtask

	task automatic check_ack(input string name, input bit exp, input bit act);
		if (act != exp) begin
			$display("mismatch %s ack: expected %b, actual %b", name, exp, act);
			$display("Something failed");
			$fatal(1);
		end
	endtask

	task automatic check_not_below(input string name, input eg_core_pkg::level_t floor,
		input eg_core_pkg::level_t act);
		if (act < floor) begin
			$display("mismatch %s release: expected at least %h, actual %h", name, floor, act);
			$display("Something failed");
			$fatal(1);
		end
	endtask

	task automatic wait_frames(input int n);
		repeat (n * 32) @(posedge clk);
		#2;
	endtask

	// full four-phase write entered and left 2 units after an edge
	task automatic host_write(input string name, input eg_cfg_pkg::slot_t slot,
		input eg_cfg_pkg::eg_field_t field, input logic [7:0] value);
		int n;
		check_ack(name, 1'b0, wr_ack); // previous write fully closed
		wr.slot  = slot;
		wr.field = field;
		wr.value = value;
		wr_req   = 1'b1;
		n = 0;
		while (wr_ack !== 1'b1 && n < 4) begin
			@(posedge clk);
			#2;
			n++;
		end
		if (wr_ack !== 1'b1) begin
			$display("%s: wr_ack did not rise within 4 clocks of wr_req", name);
			$display("Something failed");
			$fatal(1);
		end
		@(posedge clk);
		#2;
		check_ack(name, 1'b1, wr_ack); // held while req stays high
		wr_req = 1'b0;
		n = 0;
		while (wr_ack !== 1'b0 && n < 4) begin
			@(posedge clk);
			#2;
			n++;
		end
		if (wr_ack !== 1'b0) begin
			$display("%s: wr_ack did not fall within 4 clocks of wr_req dropping", name);
			$display("Something failed");
			$fatal(1);
		end
		@(posedge clk);
		#2;
		check_ack(name, 1'b0, wr_ack); // no second ack without a new req
	endtask

	initial begin
		eg_cfg_pkg::slot_t   slot;
		row_t                r;
		eg_core_pkg::level_t prev;

		clk    = 1'b0;
		rst    = 1'b1;
		wr     = '0;
		wr_req = 1'b0;
		cycles = 0;
		limit  = 0;
		for (int i = 0; i < eg_cfg_pkg::NUM_SLOTS; i++)
			last_eg[i] = '0;
		void'($urandom(32'h262e));

		// settled level is d1l x 32 plus tl x 8 where d1l 15 counts as 16
		rows[0] = '{5'd31, 5'd0, 4'd0, 5'd0, 4'd0, 7'd0, KEY_ON, 10'd20, 10'(0 * 8)};
		rows[1] = '{5'd31, 5'd0, 4'd0, 5'd0, 4'd0, 7'd45, KEY_ON, 10'd20, 10'(45 * 8)};
		rows[2] = '{5'd31, 5'd31, 4'd3, 5'd0, 4'd0, 7'd10, KEY_ON, 10'd50, 10'(3 * 32 + 10 * 8)};
		rows[3] = '{5'd31, 5'd31, 4'd15, 5'd0, 4'd0, 7'd20, KEY_ON, 10'd210,
			10'(16 * 32 + 20 * 8)};
		rows[4] = '{5'd31, 5'd0, 4'd0, 5'd0, 4'd15, 7'd64, KEY_OFF, 10'd200, 10'h3FF};
		rows[5] = '{5'd31, 5'd31, 4'd1, 5'd0, 4'd0, 7'd127, KEY_ON, 10'd20, 10'h3FF};
		names[0] = "instant attack tl 0";
		names[1] = "instant attack tl 45";
		names[2] = "decay to d1l 3";
		names[3] = "decay to d1l 15";
		names[4] = "release rr 15";
		names[5] = "tl 127 clamp";

		for (int i = 0; i < NUM_ROWS; i++)
			limit = limit + int'(rows[i].frames) * 32;
		limit = limit + 2000;

		repeat (3) @(posedge clk);
		#2;
		rst = 1'b0;

		wait_frames(2); // pipeline fill plus one full frame
		for (int i = 0; i < eg_cfg_pkg::NUM_SLOTS; i++)
			check_level("reset level", 10'h3FF, last_eg[i]);

		for (int i = 0; i < NUM_ROWS; i++) begin
			slot = eg_cfg_pkg::slot_t'($urandom % 32);
			r    = rows[i];
			host_write(names[i], slot, eg_cfg_pkg::FLD_AR, {3'b000, r.ar});
			host_write(names[i], slot, eg_cfg_pkg::FLD_D1R, {3'b000, r.d1r});
			host_write(names[i], slot, eg_cfg_pkg::FLD_D2R, {3'b000, r.d2r});
			host_write(names[i], slot, eg_cfg_pkg::FLD_RR, {4'b0000, r.rr});
			host_write(names[i], slot, eg_cfg_pkg::FLD_D1L_KS, {r.d1l, 4'b0000});
			host_write(names[i], slot, eg_cfg_pkg::FLD_TL, {1'b0, r.tl});
			if (r.key == KEY_OFF) begin
				// instant attack first so release climbs from level 0
				host_write(names[i], slot, eg_cfg_pkg::FLD_KEYON, 8'h00);
				wait_frames(1);
				check_level(names[i], 10'(int'(r.tl) * 8), last_eg[slot]);
				host_write(names[i], slot, eg_cfg_pkg::FLD_KEYOFF, 8'h00);
				wait_frames(1); // keyoff now visible
				prev = last_eg[slot];
				for (int f = 1; f < int'(r.frames); f++) begin
					wait_frames(1);
					check_not_below(names[i], prev, last_eg[slot]);
					prev = last_eg[slot];
				end
			end else begin
				host_write(names[i], slot, eg_cfg_pkg::FLD_KEYON, 8'h00);
				wait_frames(int'(r.frames));
			end
			check_level(names[i], r.exp, last_eg[slot]);
		end

		$display("Everything OK");
		$finish;
	end

endmodule

//--- src/eg_top.sv
//==========================================================
// envelope generator top: slot controller, level and state
// rings and the shared envelope datapath
//==========================================================
module eg_top (
	input  logic                clk,
	input  logic                rst,
	input  eg_cfg_pkg::eg_wr_t  wr,
	input  logic                wr_req,
	output logic                wr_ack,
	output eg_core_pkg::level_t eg,
	output eg_cfg_pkg::slot_t   out_slot
);

	eg_core_pkg::eg_slot_t  cur;
	logic                   frame;
	eg_core_pkg::level_t    lvl_old;
	eg_core_pkg::level_t    lvl_new;
	eg_core_pkg::eg_state_t st_old;
	eg_core_pkg::eg_state_t st_new;
	logic [1:0]             st_ring_out;

	assign st_old = eg_core_pkg::eg_state_t'(st_ring_out);

	eg_slot_ctrl u_slot_ctrl (
		.clk    (clk),
		.rst    (rst),
		.wr     (wr),
		.wr_req (wr_req),
		.wr_ack (wr_ack),
		.cur    (cur),
		.frame  (frame)
	);

	eg_delay_line #(
		.width  ($bits(eg_core_pkg::level_t)),
		.stages (eg_core_pkg::LEVEL_RING)
	) u_level_ring (
		.clk  (clk),
		.rst  (rst),
		.din  (lvl_new),
		.dout (lvl_old)
	);

	eg_delay_line #(
		.width  ($bits(eg_core_pkg::eg_state_t)),
		.stages (eg_core_pkg::STATE_RING)
	) u_state_ring (
		.clk  (clk),
		.rst  (rst),
		.din  (st_new),
		.dout (st_ring_out)
	);

	eg_envelope u_envelope (
		.clk      (clk),
		.rst      (rst),
		.cur      (cur),
		.frame    (frame),
		.lvl_old  (lvl_old),
		.st_old   (st_old),
		.lvl_new  (lvl_new),
		.st_new   (st_new),
		.eg       (eg),
		.out_slot (out_slot)
	);

endmodule

//--- src/eg_envelope.sv
//==========================================================
// envelope update: ADSR state machine, global rate counter,
// step patterns, total level sum and output clamp
//==========================================================
module eg_envelope (
	input  logic                   clk,
	input  logic                   rst,
	input  eg_core_pkg::eg_slot_t  cur,
	input  logic                   frame,
	input  eg_core_pkg::level_t    lvl_old,
	input  eg_core_pkg::eg_state_t st_old,
	output eg_core_pkg::level_t    lvl_new,
	output eg_core_pkg::eg_state_t st_new,
	output eg_core_pkg::level_t    eg,
	output eg_cfg_pkg::slot_t      out_slot
);

	logic [1:0]  frame_div;
	logic [14:0] rate_cnt;
	logic        tick;     // counter moved this frame

	eg_core_pkg::eg_state_t st_mid;
	logic [4:0]             d1_thr;
	eg_cfg_pkg::rate5_t     rate_cfg;
	logic [6:0]             rate_sum;
	eg_core_pkg::rate6_t    rate;

	logic [3:0]  shift;
	logic [14:0] cnt_shr;
	logic        aligned;
	logic [2:0]  win;
	logic [7:0]  pattern;
	logic        sel;
	logic        move;

	logic [3:0]          inc;
	logic [10:0]         dec_sum;
	logic [9:0]          atk_base;
	logic [9:0]          atk_dec;
	eg_core_pkg::level_t atk_lvl;

	eg_core_pkg::level_t lvl_q;
	eg_cfg_pkg::tl_t     tl_q;
	eg_cfg_pkg::slot_t   slot_q;
	logic [10:0]         out_sum;

	// global rate counter, one count every 3 frames
	always_ff @(posedge clk) begin
		if (rst) begin
			frame_div <= '0;
			rate_cnt  <= '0;
			tick      <= 1'b0;
		end else if (frame) begin
			if (frame_div == 2'd2) begin
				frame_div <= '0;
				rate_cnt  <= rate_cnt + 1'b1;
				tick      <= 1'b1;
			end else begin
				frame_div <= frame_div + 1'b1;
				tick      <= 1'b0;
			end
		end
	end

	// state selection
	always_comb begin
		d1_thr = (cur.cfg.d1l == 4'd15) ? 5'd16 : {1'b0, cur.cfg.d1l};
		st_mid = st_old;
		if (st_old == eg_core_pkg::ATTACK && lvl_old == '0)
			st_mid = eg_core_pkg::DECAY1;
		if (st_mid == eg_core_pkg::DECAY1 && lvl_old[9:5] >= d1_thr)
			st_mid = eg_core_pkg::DECAY2; // d1l 0 falls straight through
		if (cur.keyoff)
			st_new = eg_core_pkg::RELEASE;
		else if (cur.keyon)
			st_new = eg_core_pkg::ATTACK;
		else
			st_new = st_mid;
	end

	// effective rate with key scaling
	always_comb begin
		case (st_new)
			eg_core_pkg::ATTACK:  rate_cfg = cur.cfg.ar;
			eg_core_pkg::DECAY1:  rate_cfg = cur.cfg.d1r;
			eg_core_pkg::DECAY2:  rate_cfg = cur.cfg.d2r;
			default:              rate_cfg = {cur.cfg.rr, 1'b1};
		endcase
		if (rate_cfg == '0)
			rate_sum = '0;
		else
			rate_sum = {1'b0, rate_cfg, 1'b0}
				+ ({2'b00, cur.cfg.keycode} >> (2'd3 - cur.cfg.ks));
		rate = rate_sum[6] ? 6'd63 : rate_sum[5:0];
	end

	// counter window and step pattern
	always_comb begin
		if (st_new == eg_core_pkg::ATTACK)
			shift = (rate[5:2] >= 4'd11) ? 4'd0 : 4'd11 - rate[5:2]; // attack runs 2x
		else
			shift = (rate[5:2] >= 4'd12) ? 4'd0 : 4'd12 - rate[5:2];
		cnt_shr = rate_cnt >> shift;
		win     = cnt_shr[2:0];
		aligned = (rate_cnt & ((15'd1 << shift) - 15'd1)) == 15'd0;

		if (rate[5:4] == 2'b11) begin
			if (rate[5:2] == 4'hf && st_new == eg_core_pkg::ATTACK)
				pattern = 8'b1111_1111;
			else
				case (rate[1:0])
					2'd0: pattern = 8'b0000_0000;
					2'd1: pattern = 8'b1000_1000;
					2'd2: pattern = 8'b1010_1010;
					default: pattern = 8'b1110_1110;
				endcase
		end else if (rate[5:2] == 4'd0 && st_new != eg_core_pkg::ATTACK) begin
			pattern = 8'b1111_1110; // slowest decays
		end else begin
			case (rate[1:0])
				2'd0: pattern = 8'b1010_1010;
				2'd1: pattern = 8'b1110_1010;
				2'd2: pattern = 8'b1110_1110;
				default: pattern = 8'b1111_1110;
			endcase
		end
		sel = pattern[win];

		// high rates move every tick, the pattern picks the size
		move = tick && aligned && (rate[5:1] != 5'd0)
			&& (rate[5:4] == 2'b11 || sel);
	end

	// step amounts
	always_comb begin
		case (rate[5:2])
			4'd12: inc = sel ? 4'd2 : 4'd1;
			4'd13: inc = sel ? 4'd4 : 4'd2;
			4'd14: inc = sel ? 4'd8 : 4'd4;
			4'd15: inc = 4'd8;
			default: inc = 4'd1;
		endcase
		dec_sum = {1'b0, lvl_old} + {7'd0, inc};

		case (rate[5:2])
			4'd13: atk_base = lvl_old >> 3;
			4'd14, 4'd15: atk_base = lvl_old >> 2;
			default: atk_base = lvl_old >> 4;
		endcase
		atk_dec = atk_base + 1'b1;
		if (rate[5:4] == 2'b11 && sel)
			atk_dec = atk_dec << 1;
		atk_lvl = (lvl_old > atk_dec) ? lvl_old - atk_dec : '0;
	end

	// new level back to the ring
	always_comb begin
		lvl_new = lvl_old;
		if (st_new == eg_core_pkg::ATTACK) begin
			if (cur.keyon) begin
				if (cur.cfg.ar == 5'd31)
					lvl_new = '0; // instant attack
			end else if (move && lvl_old != '0) begin
				lvl_new = (rate[5:1] == 5'd31) ? '0 : atk_lvl;
			end
		end else if (move) begin
			lvl_new = dec_sum[10] ? '1 : dec_sum[9:0]; // saturate at silence
		end
	end

	assign out_sum = {1'b0, lvl_q} + {1'b0, tl_q, 3'b000};

	// two output stages, out_slot travels with eg
	always_ff @(posedge clk) begin
		if (rst) begin
			lvl_q    <= '1;
			tl_q     <= '0;
			slot_q   <= '0;
			eg       <= '1;
			out_slot <= '0;
		end else begin
			lvl_q    <= lvl_new;
			tl_q     <= cur.cfg.tl;
			slot_q   <= cur.slot;
			eg       <= out_sum[10] ? '1 : out_sum[9:0];
			out_slot <= slot_q;
		end
	end

endmodule

//--- src/eg_slot_ctrl.sv
//==========================================================
// slot controller: four-phase host writes, per-slot setting
// store, pending key events and the slot/frame sequencer
//==========================================================
module eg_slot_ctrl (
	input  logic                  clk,
	input  logic                  rst,
	input  eg_cfg_pkg::eg_wr_t    wr,
	input  logic                  wr_req,
	output logic                  wr_ack,
	output eg_core_pkg::eg_slot_t cur,
	output logic                  frame
);

	eg_cfg_pkg::eg_slot_cfg_t cfg_mem [eg_cfg_pkg::NUM_SLOTS];

	logic [eg_cfg_pkg::NUM_SLOTS-1:0] keyon_pend;
	logic [eg_cfg_pkg::NUM_SLOTS-1:0] keyoff_pend;

	eg_cfg_pkg::slot_t slot_cnt;
	logic              wr_take;

	assign wr_take = wr_req && !wr_ack; // new command only once ack is low

	// handshake: ack follows req one clock later in both directions
	always_ff @(posedge clk) begin
		if (rst)
			wr_ack <= 1'b0;
		else if (wr_take)
			wr_ack <= 1'b1;
		else if (!wr_req && wr_ack)
			wr_ack <= 1'b0;
	end

	// setting store, cleared so idle slots hold still
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < eg_cfg_pkg::NUM_SLOTS; i++)
				cfg_mem[i] <= '0;
		end else if (wr_take) begin
			case (wr.field)
				eg_cfg_pkg::FLD_AR:      cfg_mem[wr.slot].ar <= wr.value[4:0];
				eg_cfg_pkg::FLD_D1R:     cfg_mem[wr.slot].d1r <= wr.value[4:0];
				eg_cfg_pkg::FLD_D2R:     cfg_mem[wr.slot].d2r <= wr.value[4:0];
				eg_cfg_pkg::FLD_RR:      cfg_mem[wr.slot].rr <= wr.value[3:0];
				eg_cfg_pkg::FLD_D1L_KS: begin
					cfg_mem[wr.slot].d1l <= wr.value[7:4];
					cfg_mem[wr.slot].ks  <= wr.value[1:0];
				end
				eg_cfg_pkg::FLD_KEYCODE: cfg_mem[wr.slot].keycode <= wr.value[4:0];
				eg_cfg_pkg::FLD_TL:      cfg_mem[wr.slot].tl <= wr.value[6:0];
				default: ; // key events go to the pending flags
			endcase
		end
	end

	// slot sequencer and key pulses
	always_ff @(posedge clk) begin
		if (rst) begin
			slot_cnt    <= '0;
			keyon_pend  <= '0;
			keyoff_pend <= '0;
			cur         <= '0;
			frame       <= 1'b0;
		end else begin
			slot_cnt   <= slot_cnt + 1'b1; // wraps at 32
			frame      <= (slot_cnt == '0);
			cur.slot   <= slot_cnt;
			cur.cfg    <= cfg_mem[slot_cnt];
			cur.keyoff <= keyoff_pend[slot_cnt];
			cur.keyon  <= keyon_pend[slot_cnt] & ~keyoff_pend[slot_cnt]; // keyoff wins

			// issued once, then cleared
			keyon_pend[slot_cnt]  <= 1'b0;
			keyoff_pend[slot_cnt] <= 1'b0;

			// a fresh event for the slot being served waits a full frame
			if (wr_take && wr.field == eg_cfg_pkg::FLD_KEYON)
				keyon_pend[wr.slot] <= 1'b1;
			if (wr_take && wr.field == eg_cfg_pkg::FLD_KEYOFF)
				keyoff_pend[wr.slot] <= 1'b1;
		end
	end

endmodule

//--- src/eg_delay_line.sv
//==========================================================
// circulating shift register, one entry per slot, reset to ones
//==========================================================
module eg_delay_line #(
	parameter int width  = 10,
	parameter int stages = 32
) (
	input  logic             clk,
	input  logic             rst,
	input  logic [width-1:0] din,
	output logic [width-1:0] dout
);

	logic [width-1:0] sh [stages];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < stages; i++)
				sh[i] <= '1; // silent level, release state
		end else begin
			sh[0] <= din;
			for (int i = 1; i < stages; i++)
				sh[i] <= sh[i-1];
		end
	end

	assign dout = sh[stages-1];

endmodule

//--- src/eg_core_pkg.sv
//==========================================================
// envelope-side types: attenuation level, effective rate,
// state encoding and the per-clock slot record
//==========================================================
package eg_core_pkg;

	localparam int LEVEL_RING = 32; // one stage per slot
	localparam int STATE_RING = 32;

	// 1 LSB is about 0.094 dB, all ones is silence
	typedef logic [9:0] level_t;

	typedef logic [5:0] rate6_t;

	// release is all ones so the rings reset into it
	typedef enum logic [1:0] {
		ATTACK  = 2'd0,
		DECAY1  = 2'd1,
		DECAY2  = 2'd2,
		RELEASE = 2'd3
	} eg_state_t;

	// handed from the slot controller to the envelope each clock
	typedef struct packed {
		eg_cfg_pkg::slot_t        slot;
		eg_cfg_pkg::eg_slot_cfg_t cfg;
		logic                     keyon;  // single-visit pulse
		logic                     keyoff; // single-visit pulse
	} eg_slot_t;

endpackage

//--- src/eg_cfg_pkg.sv
//==========================================================
// envelope generator host-side types: slot index, per-slot
// settings and the write command from the host port
//==========================================================
package eg_cfg_pkg;

	localparam int NUM_SLOTS = 32; // operator slots per frame

	typedef logic [4:0] slot_t;
	typedef logic [4:0] rate5_t;   // attack, decay 1, decay 2
	typedef logic [3:0] rate4_t;   // release
	typedef logic [3:0] d1l_t;     // 15 stands for 16
	typedef logic [1:0] ks_t;
	typedef logic [4:0] keycode_t;
	typedef logic [6:0] tl_t;

	// write target; value bits used are the LSBs of the field,
	// except d1l_ks which takes d1l from [7:4] and ks from [1:0]
	typedef enum logic [3:0] {
		FLD_AR      = 4'd0,
		FLD_D1R     = 4'd1,
		FLD_D2R     = 4'd2,
		FLD_RR      = 4'd3,
		FLD_D1L_KS  = 4'd4,
		FLD_KEYCODE = 4'd5,
		FLD_TL      = 4'd6,
		FLD_KEYON   = 4'd7,
		FLD_KEYOFF  = 4'd8
	} eg_field_t;

	typedef struct packed {
		slot_t      slot;
		eg_field_t  field;
		logic [7:0] value;
	} eg_wr_t;

	typedef struct packed {
		rate5_t   ar;
		rate5_t   d1r;
		rate5_t   d2r;
		rate4_t   rr;
		d1l_t     d1l;
		ks_t      ks;
		keycode_t keycode;
		tl_t      tl;
	} eg_slot_cfg_t;

endpackage
